// ==== Makefile ====
VERILATOR ?= verilator
TOP       := int_res_tb
FILELIST  := compile.f
FLAGS     := --binary --timing --assert -Iinclude --top-module $(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+include
rtl/int_res_pkg.sv
rtl/int_res_bank_map.sv
rtl/int_res_write_pack.sv
rtl/int_res_read_unpack.sv
rtl/int_res_bank.sv
rtl/int_res_ctrl.sv
rtl/int_res_mem_top.sv
verification/int_res_assertions.sv
verification/int_res_tb.sv

// ==== include/int_res_defines.svh ====
`ifndef INT_RES_DEFINES_SVH
`define INT_RES_DEFINES_SVH

// Bank organisation
`define INT_RES_NUM_BANKS 4
`define INT_RES_BANK_DEPTH 16
`define INT_RES_BANK_AW 4

// Global word address covering all banks
`define INT_RES_AW 6

// Stored half and compute word widths
`define INT_RES_STO_W 8
`define INT_RES_COMP_W 24
`define INT_RES_COMP_Q 12

// Double format keeps 6 integer bits
`define INT_RES_DW_INT 6

`endif

// ==== rtl/int_res_bank.sv ====
`timescale 1ns/1ns
`include "int_res_defines.svh"

module int_res_bank (
    input  logic                           clk,
    input  int_res_pkg::int_res_bank_cmd_t cmd,
    output logic [`INT_RES_STO_W-1:0]      q
);

    logic [`INT_RES_STO_W-1:0] mem [`INT_RES_BANK_DEPTH];

    // Single port, q only moves on a read
    always_ff @(posedge clk) begin
        if (cmd.en) begin
            if (cmd.we) begin
                mem[cmd.offset] <= cmd.wdata;
            end else begin
                q <= mem[cmd.offset];
            end
        end
    end

endmodule

// ==== rtl/int_res_bank_map.sv ====
`timescale 1ns/1ns
`include "int_res_defines.svh"

module int_res_bank_map (
    input  logic [`INT_RES_AW-1:0]        rd_addr,
    input  logic [`INT_RES_AW-1:0]        wr_addr,
    input  int_res_pkg::int_res_format_e  rd_format,
    input  int_res_pkg::int_res_format_e  wr_format,
    output logic [`INT_RES_NUM_BANKS-1:0] rd_mask,
    output logic [`INT_RES_NUM_BANKS-1:0] wr_mask,
    output logic [`INT_RES_BANK_AW-1:0]   rd_offset,
    output logic [`INT_RES_BANK_AW-1:0]   wr_offset
);

    // Upper address bits name the bank, double width uses a bank pair
    function automatic logic [`INT_RES_NUM_BANKS-1:0] bank_mask(
        input logic [`INT_RES_AW-1:0]       addr,
        input int_res_pkg::int_res_format_e fmt
    );
        logic [`INT_RES_AW-`INT_RES_BANK_AW-1:0] bank;
        logic [`INT_RES_NUM_BANKS-1:0]           mask;
        bank = addr[`INT_RES_AW-1:`INT_RES_BANK_AW];
        mask = '0;
        if (fmt == int_res_pkg::FMT_DW) begin
            // Pair 0/2 for even bank, 1/3 for odd bank
            mask[{1'b0, bank[0]}] = 1'b1;
            mask[{1'b1, bank[0]}] = 1'b1;
        end else begin
            mask[bank] = 1'b1;
        end
        return mask;
    endfunction

    assign rd_mask   = bank_mask(rd_addr, rd_format);
    assign wr_mask   = bank_mask(wr_addr, wr_format);

    // Same offset in every bank of a pair
    assign rd_offset = rd_addr[`INT_RES_BANK_AW-1:0];
    assign wr_offset = wr_addr[`INT_RES_BANK_AW-1:0];

endmodule

// ==== rtl/int_res_ctrl.sv ====
`timescale 1ns/1ns
`include "int_res_defines.svh"

module int_res_ctrl (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             wr_valid,
    input  logic                                             rd_valid,
    input  logic                                             rsp_ready,
    input  logic [`INT_RES_NUM_BANKS-1:0]                    wr_mask,
    input  logic [`INT_RES_NUM_BANKS-1:0]                    rd_mask,
    input  logic [`INT_RES_BANK_AW-1:0]                      wr_offset,
    input  logic [`INT_RES_BANK_AW-1:0]                      rd_offset,
    input  logic [`INT_RES_STO_W-1:0]                        msh,
    input  logic [`INT_RES_STO_W-1:0]                        lsh,
    input  int_res_pkg::int_res_format_e                     rd_format,
    output logic                                             rd_ready,
    output int_res_pkg::int_res_bank_cmd_t [`INT_RES_NUM_BANKS-1:0] bank_cmd,
    output logic                                             load,
    output int_res_pkg::int_res_rd_tag_t                     tag,
    output logic                                             rsp_valid
);

    localparam int NB     = `INT_RES_NUM_BANKS;
    localparam int BANK_IW = $clog2(NB);

    logic              s1_valid;
    logic              conflict;
    logic              rd_accept;
    logic              pair_write;
    logic [NB-1:0]     wr_hit;
    logic [NB-1:0]     rd_hit;
    logic [BANK_IW-1:0] rd_bank;

    // Write always wins a shared bank
    assign conflict  = wr_valid && (|(wr_mask & rd_mask));

    // Stage 1 moves on when the response register is free or leaving
    assign load      = s1_valid && (!rsp_valid || rsp_ready);
    assign rd_ready  = !conflict && (!s1_valid || load);
    assign rd_accept = rd_valid && rd_ready;

    assign wr_hit = {NB{wr_valid}} & wr_mask;
    assign rd_hit = {NB{rd_accept}} & rd_mask;

    // Two banks in the mask means a double write
    assign pair_write = |(wr_mask[NB/2-1:0] & wr_mask[NB-1:NB/2]);

    always_comb begin
        for (int b = 0; b < NB; b++) begin
            bank_cmd[b].en     = wr_hit[b] | rd_hit[b];
            bank_cmd[b].we     = wr_hit[b];
            bank_cmd[b].offset = wr_hit[b] ? wr_offset : rd_offset;
            // Lower bank of a pair takes the MSH
            bank_cmd[b].wdata  = (pair_write && b < NB / 2) ? msh : lsh;
        end
    end

    // Highest set bit, its LSB still names the pair for double reads
    always_comb begin
        rd_bank = '0;
        for (int b = 0; b < NB; b++) begin
            if (rd_mask[b]) begin
                rd_bank = BANK_IW'(b);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s1_valid  <= rd_accept || (s1_valid && !load);
            rsp_valid <= load || (rsp_valid && !rsp_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            tag.bank   <= rd_bank;
            tag.format <= rd_format;
        end
    end

endmodule

// ==== rtl/int_res_mem_top.sv ====
`timescale 1ns/1ns
`include "int_res_defines.svh"

module int_res_mem_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_valid,
    input  int_res_pkg::int_res_wr_req_t   wr_req,
    input  logic                           rd_valid,
    input  int_res_pkg::int_res_rd_req_t   rd_req,
    input  logic                           rsp_ready,
    output logic                           rd_ready,
    output logic                           rsp_valid,
    output logic [`INT_RES_COMP_W-1:0]     rsp_data
);

    logic [`INT_RES_NUM_BANKS-1:0]  wr_mask;
    logic [`INT_RES_NUM_BANKS-1:0]  rd_mask;
    logic [`INT_RES_BANK_AW-1:0]    wr_offset;
    logic [`INT_RES_BANK_AW-1:0]    rd_offset;
    logic [`INT_RES_STO_W-1:0]      msh;
    logic [`INT_RES_STO_W-1:0]      lsh;
    logic                           load;
    int_res_pkg::int_res_rd_tag_t   tag;

    int_res_pkg::int_res_bank_cmd_t [`INT_RES_NUM_BANKS-1:0] bank_cmd;
    logic [`INT_RES_NUM_BANKS-1:0][`INT_RES_STO_W-1:0]       bank_q;

    int_res_bank_map u_bank_map (
        .rd_addr   (rd_req.addr),
        .wr_addr   (wr_req.addr),
        .rd_format (rd_req.format),
        .wr_format (wr_req.format),
        .rd_mask   (rd_mask),
        .wr_mask   (wr_mask),
        .rd_offset (rd_offset),
        .wr_offset (wr_offset)
    );

    int_res_write_pack u_write_pack (
        .data   (wr_req.data),
        .format (wr_req.format),
        .msh    (msh),
        .lsh    (lsh)
    );

    int_res_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .rd_valid  (rd_valid),
        .rsp_ready (rsp_ready),
        .wr_mask   (wr_mask),
        .rd_mask   (rd_mask),
        .wr_offset (wr_offset),
        .rd_offset (rd_offset),
        .msh       (msh),
        .lsh       (lsh),
        .rd_format (rd_req.format),
        .rd_ready  (rd_ready),
        .bank_cmd  (bank_cmd),
        .load      (load),
        .tag       (tag),
        .rsp_valid (rsp_valid)
    );

    for (genvar b = 0; b < `INT_RES_NUM_BANKS; b++) begin : g_bank
        int_res_bank u_bank (
            .clk (clk),
            .cmd (bank_cmd[b]),
            .q   (bank_q[b])
        );
    end

    int_res_read_unpack u_read_unpack (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .tag      (tag),
        .q        (bank_q),
        .rsp_data (rsp_data)
    );

endmodule

// ==== rtl/int_res_pkg.sv ====
`include "int_res_defines.svh"

package int_res_pkg;

    // Stored number formats, width implied by the format
    typedef enum logic [2:0] {
        FMT_SW_1_X = 3'd0,
        FMT_SW_2_X = 3'd1,
        FMT_SW_4_X = 3'd2,
        FMT_SW_5_X = 3'd3,
        FMT_SW_6_X = 3'd4,
        FMT_DW     = 3'd5
    } int_res_format_e;

    typedef struct packed {
        logic [`INT_RES_AW-1:0]     addr;
        int_res_format_e            format;
        logic [`INT_RES_COMP_W-1:0] data;
    } int_res_wr_req_t;

    typedef struct packed {
        logic [`INT_RES_AW-1:0] addr;
        int_res_format_e        format;
    } int_res_rd_req_t;

    // Per-bank command, read when en without we
    typedef struct packed {
        logic                        en;
        logic                        we;
        logic [`INT_RES_BANK_AW-1:0] offset;
        logic [`INT_RES_STO_W-1:0]   wdata;
    } int_res_bank_cmd_t;

    // Travels with a read while its data sits on the bank outputs
    typedef struct packed {
        logic [$clog2(`INT_RES_NUM_BANKS)-1:0] bank;
        int_res_format_e                       format;
    } int_res_rd_tag_t;

endpackage

// ==== rtl/int_res_read_unpack.sv ====
`timescale 1ns/1ns
`include "int_res_defines.svh"

module int_res_read_unpack (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           load,
    input  int_res_pkg::int_res_rd_tag_t                   tag,
    input  logic [`INT_RES_NUM_BANKS-1:0][`INT_RES_STO_W-1:0] q,
    output logic [`INT_RES_COMP_W-1:0]                     rsp_data
);

    localparam int W  = `INT_RES_COMP_W;
    localparam int S  = `INT_RES_STO_W;
    localparam int Q  = `INT_RES_COMP_Q;
    localparam int DW = `INT_RES_DW_INT;

    logic [S-1:0]   single_byte;
    logic [2*S-1:0] pair;
    logic [W-1:0]   sext_single;
    logic [W-1:0]   sext_pair;
    logic [W-1:0]   unpacked;

    // MSH bank sits in the lower half of the pair
    assign single_byte = q[tag.bank];
    assign pair        = {q[{1'b0, tag.bank[0]}], q[{1'b1, tag.bank[0]}]};

    assign sext_single = {{(W - S){single_byte[S-1]}}, single_byte};
    assign sext_pair   = {{(W - 2 * S){pair[2*S-1]}}, pair};

    // Shifting the sign-extended value leaves zeros below the stored bits
    always_comb begin
        case (tag.format)
            int_res_pkg::FMT_SW_1_X: unpacked = sext_single << (Q - S + 1);
            int_res_pkg::FMT_SW_2_X: unpacked = sext_single << (Q - S + 2);
            int_res_pkg::FMT_SW_4_X: unpacked = sext_single << (Q - S + 4);
            int_res_pkg::FMT_SW_5_X: unpacked = sext_single << (Q - S + 5);
            int_res_pkg::FMT_SW_6_X: unpacked = sext_single << (Q - S + 6);
            int_res_pkg::FMT_DW:     unpacked = sext_pair << (Q + DW - 2 * S);
            default:                 unpacked = '0;
        endcase
    end

    // Response register, holds until the next load
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_data <= '0;
        end else if (load) begin
            rsp_data <= unpacked;
        end
    end

endmodule

// ==== rtl/int_res_write_pack.sv ====
`timescale 1ns/1ns
`include "int_res_defines.svh"

module int_res_write_pack (
    input  logic [`INT_RES_COMP_W-1:0]   data,
    input  int_res_pkg::int_res_format_e format,
    output logic [`INT_RES_STO_W-1:0]    msh,
    output logic [`INT_RES_STO_W-1:0]    lsh
);

    localparam int S  = `INT_RES_STO_W;
    localparam int Q  = `INT_RES_COMP_Q;
    localparam int DW = `INT_RES_DW_INT;

    // Byte for k integer bits starts at bit Q-S+k, truncation wraps
    always_comb begin
        msh = '0;
        case (format)
            int_res_pkg::FMT_SW_1_X: begin
                lsh = S'(data >> (Q - S + 1));
            end
            int_res_pkg::FMT_SW_2_X: begin
                lsh = S'(data >> (Q - S + 2));
            end
            int_res_pkg::FMT_SW_4_X: begin
                lsh = S'(data >> (Q - S + 4));
            end
            int_res_pkg::FMT_SW_5_X: begin
                lsh = S'(data >> (Q - S + 5));
            end
            int_res_pkg::FMT_SW_6_X: begin
                lsh = S'(data >> (Q - S + 6));
            end
            int_res_pkg::FMT_DW: begin
                // Bits 17..10 and 9..2
                msh = S'(data >> (Q + DW - S));
                lsh = S'(data >> (Q + DW - 2 * S));
            end
            default: begin
                lsh = '0;
            end
        endcase
    end

endmodule

// ==== verification/int_res_assertions.sv ====
`timescale 1ns/1ns
`include "int_res_defines.svh"

module int_res_assertions (
    input logic                          clk,
    input logic                          rst,
    input logic                          wr_valid,
    input int_res_pkg::int_res_wr_req_t  wr_req,
    input int_res_pkg::int_res_rd_req_t  rd_req,
    input logic                          rd_ready,
    input logic                          rsp_valid,
    input logic                          rsp_ready,
    input logic [`INT_RES_COMP_W-1:0]    rsp_data
);

    int failures = 0;

    logic [`INT_RES_NUM_BANKS-1:0] wr_banks;
    logic [`INT_RES_NUM_BANKS-1:0] rd_banks;

    // Banks touched by an access, taken straight from address and format
    function automatic logic [`INT_RES_NUM_BANKS-1:0] banks_touched(
        input logic [`INT_RES_AW-1:0]       addr,
        input int_res_pkg::int_res_format_e fmt
    );
        logic [`INT_RES_AW-`INT_RES_BANK_AW-1:0] blk;
        logic [`INT_RES_NUM_BANKS-1:0]           m;
        blk = addr[`INT_RES_AW-1:`INT_RES_BANK_AW];
        m = '0;
        if (fmt == int_res_pkg::FMT_DW) begin
            if (blk == 2'd0 || blk == 2'd2) begin
                m = 4'b0101;
            end else begin
                m = 4'b1010;
            end
        end else begin
            m[blk] = 1'b1;
        end
        return m;
    endfunction

    assign wr_banks = banks_touched(wr_req.addr, wr_req.format);
    assign rd_banks = banks_touched(rd_req.addr, rd_req.format);

    // Stalled response keeps valid and data
    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else begin
        failures++;
        $error("Response changed while rsp_ready was low");
    end

    a_rsp_reset: assert property (@(posedge clk) rst |=> !rsp_valid)
    else begin
        failures++;
        $error("rsp_valid high after reset");
    end

    // Write owns a shared bank
    a_conflict: assert property (@(posedge clk) disable iff (rst)
        wr_valid && |(wr_banks & rd_banks) |-> !rd_ready)
    else begin
        failures++;
        $error("Read offered while a write used the same bank");
    end

endmodule

bind int_res_mem_top int_res_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .wr_valid  (wr_valid),
    .wr_req    (wr_req),
    .rd_req    (rd_req),
    .rd_ready  (rd_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
);

// ==== verification/int_res_tb.sv ====
`timescale 1ns/1ns
`include "int_res_defines.svh"

module int_res_tb;

    localparam int FILL_CYCLES  = 1 << `INT_RES_AW;
    localparam int TEST_CYCLES  = 4000;
    localparam int PHASE_LEN    = 500;
    localparam int TOTAL_CYCLES = 10 + FILL_CYCLES + TEST_CYCLES + 40;
    localparam longint TIMEOUT_NS = longint'(TOTAL_CYCLES) * 20 * 4;

    logic                         clk;
    logic                         rst;
    logic                         wr_valid;
    logic                         rd_valid;
    logic                         rsp_ready;
    logic                         rd_ready;
    logic                         rsp_valid;
    logic [`INT_RES_COMP_W-1:0]   rsp_data;
    int_res_pkg::int_res_wr_req_t wr_req;
    int_res_pkg::int_res_rd_req_t rd_req;

    // Reference banks and expected responses in acceptance order
    logic [`INT_RES_STO_W-1:0]  model_mem [`INT_RES_NUM_BANKS][`INT_RES_BANK_DEPTH];
    logic [`INT_RES_COMP_W-1:0] exp_q [$];
    int                         acc_q [$];

    integer seed = 32'h66d9;
    int     errors = 0;
    int     cycle = 0;
    logic   timed_phase = 1'b0;

    int_res_mem_top dut (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .wr_req    (wr_req),
        .rd_valid  (rd_valid),
        .rd_req    (rd_req),
        .rsp_ready (rsp_ready),
        .rd_ready  (rd_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic int_res_pkg::int_res_format_e rand_format(input int n);
        return int_res_pkg::int_res_format_e'(3'(rand_below(n)));
    endfunction

    function automatic int int_bits(input int_res_pkg::int_res_format_e fmt);
        case (fmt)
            int_res_pkg::FMT_SW_1_X: return 1;
            int_res_pkg::FMT_SW_2_X: return 2;
            int_res_pkg::FMT_SW_4_X: return 4;
            int_res_pkg::FMT_SW_5_X: return 5;
            default:                 return 6;
        endcase
    endfunction

    // Pair 0/2 for address blocks 0 and 2, pair 1/3 otherwise
    function automatic int msh_bank(input logic [`INT_RES_AW-1:0] addr);
        return (addr[5:4] == 2'd0 || addr[5:4] == 2'd2) ? 0 : 1;
    endfunction

    function automatic logic [3:0] banks_used(input logic [`INT_RES_AW-1:0] addr,
                                              input int_res_pkg::int_res_format_e fmt);
        logic [3:0] m;
        m = '0;
        if (fmt == int_res_pkg::FMT_DW) begin
            m[msh_bank(addr)] = 1'b1;
            m[msh_bank(addr) + 2] = 1'b1;
        end else begin
            m[addr[5:4]] = 1'b1;
        end
        return m;
    endfunction

    // Stored bits at position lo, sign above, zeros below
    function automatic logic [23:0] place_bits(input logic [15:0] bits, input int width,
                                               input int lo);
        logic [23:0] r;
        for (int i = 0; i < 24; i++) begin
            if (i < lo)
                r[i] = 1'b0;
            else if (i < lo + width)
                r[i] = bits[i - lo];
            else
                r[i] = bits[width - 1];
        end
        return r;
    endfunction

    function automatic void model_write(input logic [`INT_RES_AW-1:0] addr,
                                        input int_res_pkg::int_res_format_e fmt,
                                        input logic [23:0] data);
        int off;
        int k;
        off = int'(addr[3:0]);
        if (fmt == int_res_pkg::FMT_DW) begin
            model_mem[msh_bank(addr)][off] = data[17:10];
            model_mem[msh_bank(addr) + 2][off] = data[9:2];
        end else begin
            k = int_bits(fmt);
            model_mem[int'(addr[5:4])][off] = data[11 + k -: 8];
        end
    endfunction

    function automatic logic [23:0] expected_read(input logic [`INT_RES_AW-1:0] addr,
                                                  input int_res_pkg::int_res_format_e fmt);
        int off;
        off = int'(addr[3:0]);
        if (fmt == int_res_pkg::FMT_DW)
            return place_bits({model_mem[msh_bank(addr)][off],
                               model_mem[msh_bank(addr) + 2][off]}, 16, 2);
        return place_bits({8'h00, model_mem[int'(addr[5:4])][off]}, 8, 4 + int_bits(fmt));
    endfunction

    task automatic drive_random();
        wr_valid       = (rand_below(2) != 0);
        wr_req.addr    = 6'(rand_below(64));
        wr_req.format  = rand_format(6);
        wr_req.data    = 24'($random(seed));
        rd_valid       = (rand_below(4) != 0);
        rd_req.addr    = 6'(rand_below(64));
        rd_req.format  = rand_format(6);
        rsp_ready      = timed_phase ? 1'b1 : (rand_below(4) != 0);
    endtask

    // Samples mid-cycle, then updates the model for the coming edge
    task automatic check_cycle();
        logic [23:0] exp;
        int          acc;
        logic        overlap;
        @(negedge clk);
        overlap = (banks_used(wr_req.addr, wr_req.format) &
                   banks_used(rd_req.addr, rd_req.format)) != 4'b0;
        if (wr_valid && overlap) begin
            assert (rd_ready === 1'b0) else begin
                errors++;
                $display("ERR %0t rd_ready expected 0 actual %b", $time, rd_ready);
            end
        end else if (timed_phase) begin
            assert (rd_ready === 1'b1) else begin
                errors++;
                $display("ERR %0t rd_ready expected 1 actual %b", $time, rd_ready);
            end
        end
        if (rsp_valid && rsp_ready) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Response at %0t arrived with no read outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                acc = acc_q.pop_front();
                assert (rsp_data === exp) else begin
                    errors++;
                    $display("ERR %0t rsp_data expected %h actual %h", $time, exp, rsp_data);
                end
                if (acc >= 0 && timed_phase) begin
                    assert (cycle == acc + 2) else begin
                        errors++;
                        $display("Response at %0t came %0d cycles after acceptance, not 2",
                                 $time, cycle - acc);
                    end
                end
            end
        end
        if (rd_valid && rd_ready) begin
            exp_q.push_back(expected_read(rd_req.addr, rd_req.format));
            acc_q.push_back(timed_phase ? cycle : -1);
        end
        if (wr_valid)
            model_write(wr_req.addr, wr_req.format, wr_req.data);
        cycle++;
    endtask

    initial begin
        int total;
        rst       = 1'b1;
        wr_valid  = 1'b0;
        rd_valid  = 1'b0;
        rsp_ready = 1'b0;
        wr_req    = '0;
        rd_req    = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        assert (rsp_valid === 1'b0) else begin
            errors++;
            $display("ERR %0t rsp_valid expected 0 actual %b", $time, rsp_valid);
        end
        assert (rd_ready === 1'b1) else begin
            errors++;
            $display("ERR %0t rd_ready expected 1 actual %b", $time, rd_ready);
        end

        // Banks come up unknown, so every address gets a single write first
        for (int a = 0; a < FILL_CYCLES; a++) begin
            @(posedge clk);
            #2;
            wr_valid      = 1'b1;
            wr_req.addr   = 6'(a);
            wr_req.format = rand_format(5);
            wr_req.data   = 24'($random(seed));
            rsp_ready     = 1'b1;
            check_cycle();
        end

        // First read after reset
        @(posedge clk);
        #2;
        wr_valid      = 1'b0;
        rd_valid      = 1'b1;
        rd_req.addr   = 6'(rand_below(64));
        rd_req.format = rand_format(6);
        check_cycle();
        assert (rd_ready === 1'b1) else begin
            errors++;
            $display("First read after reset was not accepted at %0t", $time);
        end

        // Alternating blocks of random and always-high rsp_ready
        for (int i = 0; i < TEST_CYCLES; i++) begin
            timed_phase = ((i / PHASE_LEN) % 2) == 1;
            @(posedge clk);
            #2;
            drive_random();
            check_cycle();
        end

        // Drain, then a few idle cycles to catch stray responses
        for (int d = 0; d < 40 && (exp_q.size() != 0 || d < 4); d++) begin
            @(posedge clk);
            #2;
            wr_valid  = 1'b0;
            rd_valid  = 1'b0;
            rsp_ready = 1'b1;
            check_cycle();
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected responses never arrived", exp_q.size());
        end

        total = errors + dut.u_assertions.failures;
        $display("Errors: %0d (checks %0d, assertions %0d)", total, errors,
                 dut.u_assertions.failures);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the test sequence completed");
        $display("TESTS FAILED");
        $finish;
    end

endmodule
